/* common/fetch_defines.svh */
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// ---------------------------------------------------------------------------
// Fetch subsystem parameters
// ---------------------------------------------------------------------------

// First pc after reset
`define FETCH_RESET_PC 32'h3000_0000

// Direct-mapped cache geometry
`define ICACHE_LINES 16
`define ICACHE_LINE_WORDS 4

// AXI id on every line refill
`define FETCH_AXI_ID 0

`endif

/* common/fetch_pkg.sv */
`include "fetch_defines.svh"

package fetch_pkg;

    // Address split widths from the cache geometry
    localparam int INDEX_W = $clog2(`ICACHE_LINES);
    localparam int WORD_SEL_W = $clog2(`ICACHE_LINE_WORDS);
    localparam int TAG_W = 32 - INDEX_W - WORD_SEL_W - 2;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [WORD_SEL_W-1:0] word_sel_t;

    // Fetch unit to cache
    typedef struct packed {
        addr_t pc;
    } fetch_req_t;

    typedef struct packed {
        inst_t inst;
    } fetch_resp_t;

    // ------------------------------------------------------------------------
    // Memory read channels
    // ------------------------------------------------------------------------
    typedef struct packed {
        addr_t      addr;
        logic [3:0] id;
        logic [7:0] len;
        logic [2:0] size;
        logic [1:0] burst;
    } mem_ar_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  id;
        logic [1:0]  resp;
        logic        last;
    } mem_r_t;

    typedef enum logic [2:0] {
        idle,
        lookup,
        refill_addr,
        refill_data,
        respond
    } icache_state_t;

endpackage

/* hdl/fetch_unit.sv */
`include "fetch_defines.svh"

module fetch_unit (
    input  logic                   clock,
    input  logic                   reset,
    // Control from decode
    input  logic                   redirect_valid,
    input  fetch_pkg::addr_t       redirect_pc,
    input  logic                   hold,
    // Request to cache
    output logic                   req_valid,
    output fetch_pkg::fetch_req_t  req,
    input  logic                   req_ready,
    // Response from cache is always accepted
    input  logic                   resp_valid,
    input  fetch_pkg::fetch_resp_t resp,
    // Instruction toward decode
    output logic                   inst_valid,
    output fetch_pkg::addr_t       inst_pc,
    output fetch_pkg::inst_t       inst,
    input  logic                   inst_ready
);

    fetch_pkg::addr_t pc;
    fetch_pkg::addr_t next_pc;
    fetch_pkg::addr_t redirect_pc_q;
    logic             redirect_q;
    logic             hold_q;
    logic             boot;
    logic             outstanding;
    logic             handoff;

    assign handoff = inst_valid && inst_ready;
    assign req.pc = pc;

    // Hold beats redirect and a captured redirect beats a live one
    always_comb begin
        if (hold_q || hold) begin
            next_pc = pc;
        end else if (redirect_q) begin
            next_pc = redirect_pc_q;
        end else if (redirect_valid) begin
            next_pc = redirect_pc;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    // -------------------------------------------------------------------------
    // Redirect and hold capture between handoffs
    // -------------------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            redirect_q <= 1'b0;
            hold_q <= 1'b0;
        end else if (handoff) begin
            redirect_q <= 1'b0;
            hold_q <= 1'b0;
        end else begin
            if (redirect_valid) begin
                redirect_q <= 1'b1;
            end
            if (hold) begin
                hold_q <= 1'b1;
            end
        end
    end

    // First redirect wins
    always_ff @(posedge clock) begin
        if (!handoff && redirect_valid && !redirect_q) begin
            redirect_pc_q <= redirect_pc;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= `FETCH_RESET_PC;
        end else if (handoff) begin
            pc <= next_pc;
        end
    end

    // -------------------------------------------------------------------------
    // Request issue with one in flight
    // -------------------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            boot <= 1'b1;
            req_valid <= 1'b0;
            outstanding <= 1'b0;
        end else begin
            boot <= 1'b0;
            if (boot || handoff) begin
                req_valid <= 1'b1;
            end else if (req_valid && req_ready) begin
                req_valid <= 1'b0;
            end
            if (req_valid && req_ready) begin
                outstanding <= 1'b1;
            end else if (resp_valid) begin
                outstanding <= 1'b0;
            end
        end
    end

    // Output register toward decode
    always_ff @(posedge clock) begin
        if (reset) begin
            inst_valid <= 1'b0;
        end else if (resp_valid) begin
            inst_valid <= 1'b1;
        end else if (handoff) begin
            inst_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (resp_valid) begin
            inst <= resp.inst;
            inst_pc <= pc;
        end
    end

    a_inst_stable: assert property (@(posedge clock) disable iff (reset)
        inst_valid && !inst_ready |=> inst_valid && $stable(inst) && $stable(inst_pc));

    a_resp_outstanding: assert property (@(posedge clock) disable iff (reset)
        resp_valid |-> outstanding);

endmodule

/* icache/icache.sv */
`include "fetch_defines.svh"

module icache (
    input  logic                   clock,
    input  logic                   reset,
    // Request from fetch unit
    input  logic                   req_valid,
    input  fetch_pkg::fetch_req_t  req,
    output logic                   req_ready,
    // One-cycle response
    output logic                   resp_valid,
    output fetch_pkg::fetch_resp_t resp,
    // Memory read address channel
    output logic                   mem_ar_valid,
    output fetch_pkg::mem_ar_t     mem_ar,
    input  logic                   mem_ar_ready,
    // Memory read data channel
    input  logic                   mem_r_valid,
    input  fetch_pkg::mem_r_t      mem_r,
    output logic                   mem_r_ready
);

    // Byte offset, word select, index, tag from low to high
    localparam int WORD_LSB = 2;
    localparam int INDEX_LSB = WORD_LSB + $bits(fetch_pkg::word_sel_t);
    localparam int TAG_LSB = INDEX_LSB + $bits(fetch_pkg::index_t);
    localparam int DATA_WORDS = `ICACHE_LINES * `ICACHE_LINE_WORDS;

    fetch_pkg::icache_state_t state;
    fetch_pkg::addr_t         req_pc;
    fetch_pkg::tag_t          req_tag;
    fetch_pkg::index_t        req_index;
    fetch_pkg::word_sel_t     req_word;
    fetch_pkg::word_sel_t     beat;
    logic                     hit;

    logic [`ICACHE_LINES-1:0] line_valid;
    fetch_pkg::tag_t          tag_array [`ICACHE_LINES];
    fetch_pkg::inst_t         data_array [DATA_WORDS];

    assign req_tag = req_pc[TAG_LSB +: $bits(fetch_pkg::tag_t)];
    assign req_index = req_pc[INDEX_LSB +: $bits(fetch_pkg::index_t)];
    assign req_word = req_pc[WORD_LSB +: $bits(fetch_pkg::word_sel_t)];

    assign hit = line_valid[req_index] && (tag_array[req_index] == req_tag);

    // Request pc held for the whole lookup/refill
    always_ff @(posedge clock) begin
        if (req_valid && req_ready) begin
            req_pc <= req.pc;
        end
    end

    // -------------------------------------------------------------------------
    // Lookup and refill FSM
    // -------------------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= fetch_pkg::idle;
        end else begin
            case (state)
                fetch_pkg::idle: begin
                    if (req_valid) begin
                        state <= fetch_pkg::lookup;
                    end
                end
                fetch_pkg::lookup: begin
                    state <= hit ? fetch_pkg::respond : fetch_pkg::refill_addr;
                end
                fetch_pkg::refill_addr: begin
                    if (mem_ar_ready) begin
                        state <= fetch_pkg::refill_data;
                    end
                end
                fetch_pkg::refill_data: begin
                    if (mem_r_valid && mem_r.last) begin
                        state <= fetch_pkg::respond;
                    end
                end
                default: begin
                    state <= fetch_pkg::idle;
                end
            endcase
        end
    end

    // Beat counter and valid bits
    always_ff @(posedge clock) begin
        if (reset) begin
            beat <= '0;
            line_valid <= '0;
        end else if (state == fetch_pkg::refill_addr) begin
            beat <= '0;
        end else if (mem_r_valid && mem_r_ready) begin
            beat <= beat + 1'b1;
            if (mem_r.last) begin
                line_valid[req_index] <= 1'b1;
            end
        end
    end

    // Line fill with beats in address order
    always_ff @(posedge clock) begin
        if (mem_r_valid && mem_r_ready) begin
            data_array[{req_index, beat}] <= mem_r.data;
            if (mem_r.last) begin
                tag_array[req_index] <= req_tag;
            end
        end
    end

    assign req_ready = (state == fetch_pkg::idle);
    assign resp_valid = (state == fetch_pkg::respond);
    assign resp.inst = data_array[{req_index, req_word}];

    // -------------------------------------------------------------------------
    // Memory read channel
    // -------------------------------------------------------------------------
    assign mem_ar_valid = (state == fetch_pkg::refill_addr);
    assign mem_r_ready = (state == fetch_pkg::refill_data);

    // One incrementing burst of 4-byte beats per line
    always_comb begin
        mem_ar.addr = {req_tag, req_index, {INDEX_LSB{1'b0}}};
        mem_ar.id = 4'(`FETCH_AXI_ID);
        mem_ar.len = 8'(`ICACHE_LINE_WORDS - 1);
        mem_ar.size = 3'b010;
        mem_ar.burst = 2'b01;
    end

    a_ar_stable: assert property (@(posedge clock) disable iff (reset)
        mem_ar_valid && !mem_ar_ready |=> mem_ar_valid && $stable(mem_ar));

    a_last_in_refill: assert property (@(posedge clock) disable iff (reset)
        mem_r_valid && mem_r.last |-> state == fetch_pkg::refill_data);

endmodule

/* hdl/fetch_top.sv */
module fetch_top (
    input  logic                clock,
    input  logic                reset,
    // Decode side
    input  logic                redirect_valid,
    input  fetch_pkg::addr_t    redirect_pc,
    input  logic                hold,
    output logic                inst_valid,
    output fetch_pkg::addr_t    inst_pc,
    output fetch_pkg::inst_t    inst,
    input  logic                inst_ready,
    // Memory side
    output logic                mem_ar_valid,
    output fetch_pkg::mem_ar_t  mem_ar,
    input  logic                mem_ar_ready,
    input  logic                mem_r_valid,
    input  fetch_pkg::mem_r_t   mem_r,
    output logic                mem_r_ready
);

    logic                   req_valid;
    logic                   req_ready;
    fetch_pkg::fetch_req_t  req;
    logic                   resp_valid;
    fetch_pkg::fetch_resp_t resp;

    fetch_unit u_fetch_unit (
        .clock          (clock),
        .reset          (reset),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .hold           (hold),
        .req_valid      (req_valid),
        .req            (req),
        .req_ready      (req_ready),
        .resp_valid     (resp_valid),
        .resp           (resp),
        .inst_valid     (inst_valid),
        .inst_pc        (inst_pc),
        .inst           (inst),
        .inst_ready     (inst_ready)
    );

    icache u_icache (
        .clock        (clock),
        .reset        (reset),
        .req_valid    (req_valid),
        .req          (req),
        .req_ready    (req_ready),
        .resp_valid   (resp_valid),
        .resp         (resp),
        .mem_ar_valid (mem_ar_valid),
        .mem_ar       (mem_ar),
        .mem_ar_ready (mem_ar_ready),
        .mem_r_valid  (mem_r_valid),
        .mem_r        (mem_r),
        .mem_r_ready  (mem_r_ready)
    );

endmodule

/* tb/tb_clock.sv */
module tb_clock (
    output logic clock,
    output logic reset
);

    // 40 unit period
    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Reset held for three rising edges and released just after the third
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clock);
        #5;
        reset = 1'b0;
    end

endmodule

/* tb/tb_fetch_top.sv */
`include "fetch_defines.svh"

module tb_fetch_top;

    localparam int ACT_NEXT = 0;
    localparam int ACT_REDIRECT = 1;
    localparam int ACT_HOLD = 2;
    localparam int WAIT_LIMIT = 200;
    localparam int LINE_BYTES = `ICACHE_LINE_WORDS * 4;

    // One handoff per row with its expected pc, stall cycles and action
    typedef struct packed {
        logic [1:0]  action;
        logic [31:0] target;
        logic [3:0]  stall;
        logic [31:0] pc;
    } row_t;

    logic               clock;
    logic               reset;
    logic               redirect_valid;
    fetch_pkg::addr_t   redirect_pc;
    logic               hold;
    logic               inst_valid;
    fetch_pkg::addr_t   inst_pc;
    fetch_pkg::inst_t   inst;
    logic               inst_ready;
    logic               mem_ar_valid;
    fetch_pkg::mem_ar_t mem_ar;
    logic               mem_ar_ready;
    logic               mem_r_valid;
    fetch_pkg::mem_r_t  mem_r;
    logic               mem_r_ready;

    row_t               rows [$];
    integer             seed = 51;
    int                 errors = 0;
    int                 test_errors = 0;
    int                 tests = 0;
    int                 failed_tests = 0;
    int                 burst_count = 0;
    bit                 timed_out = 1'b0;
    // Pc whose line any refill burst must fetch
    logic [31:0]        pending_pc;

    // Memory model state
    bit                 burst_active;
    logic [31:0]        burst_addr;
    int                 beat_idx;
    logic               ar_valid_s;
    fetch_pkg::mem_ar_t ar_s;
    logic               r_ready_s;

    tb_clock u_clock (
        .clock (clock),
        .reset (reset)
    );

    fetch_top UUT (
        .clock          (clock),
        .reset          (reset),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .hold           (hold),
        .inst_valid     (inst_valid),
        .inst_pc        (inst_pc),
        .inst           (inst),
        .inst_ready     (inst_ready),
        .mem_ar_valid   (mem_ar_valid),
        .mem_ar         (mem_ar),
        .mem_ar_ready   (mem_ar_ready),
        .mem_r_valid    (mem_r_valid),
        .mem_r          (mem_r),
        .mem_r_ready    (mem_r_ready)
    );

    // Memory contents are a fixed function of the address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return addr ^ 32'hA5A5_A5A5;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("error %0t: %s = %h, expected %h", $time, name, got, expected);
            errors++;
            test_errors++;
        end
    endtask

    task automatic add_row(input int action, input logic [31:0] target,
                           input int stall, input logic [31:0] pc);
        row_t r;
        r.action = 2'(action);
        r.target = target;
        r.stall = 4'(stall);
        r.pc = pc;
        rows.push_back(r);
    endtask

    task automatic load_table();
        add_row(ACT_NEXT, 32'h0, 0, 32'h3000_0000);
        add_row(ACT_NEXT, 32'h0, 2, 32'h3000_0004);
        add_row(ACT_NEXT, 32'h0, 0, 32'h3000_0008);
        add_row(ACT_NEXT, 32'h0, 0, 32'h3000_000C);
        add_row(ACT_REDIRECT, 32'h3000_0084, 1, 32'h3000_0010);
        add_row(ACT_NEXT, 32'h0, 0, 32'h3000_0084);
        add_row(ACT_HOLD, 32'h0, 0, 32'h3000_0088);
        add_row(ACT_NEXT, 32'h0, 3, 32'h3000_0088);
        add_row(ACT_NEXT, 32'h0, 0, 32'h3000_008C);
        // Redirect back to the start so the first lines hit
        add_row(ACT_REDIRECT, 32'h3000_0000, 0, 32'h3000_0090);
        add_row(ACT_NEXT, 32'h0, 0, 32'h3000_0000);
        add_row(ACT_NEXT, 32'h0, 0, 32'h3000_0004);
        add_row(ACT_HOLD, 32'h0, 1, 32'h3000_0008);
        add_row(ACT_NEXT, 32'h0, 0, 32'h3000_0008);
        add_row(ACT_NEXT, 32'h0, 0, 32'h3000_000C);
        add_row(ACT_REDIRECT, 32'h3000_00F8, 0, 32'h3000_0010);
        add_row(ACT_NEXT, 32'h0, 2, 32'h3000_00F8);
        add_row(ACT_NEXT, 32'h0, 0, 32'h3000_00FC);
        add_row(ACT_REDIRECT, 32'h3000_0084, 0, 32'h3000_0100);
        add_row(ACT_HOLD, 32'h0, 0, 32'h3000_0084);
        add_row(ACT_NEXT, 32'h0, 1, 32'h3000_0084);
    endtask

    // Distinct cache lines among the table's pcs
    function automatic int count_lines();
        logic [31:0] seen [$];
        logic [31:0] line;
        bit          found;
        foreach (rows[i]) begin
            line = rows[i].pc & ~32'(LINE_BYTES - 1);
            found = 1'b0;
            foreach (seen[j]) begin
                if (seen[j] == line) begin
                    found = 1'b1;
                end
            end
            if (!found) begin
                seen.push_back(line);
            end
        end
        return seen.size();
    endfunction

    task automatic report_test(input string label);
        tests++;
        if (test_errors == 0) begin
            $display("test %s: ok", label);
        end else begin
            $display("test %s: %0d errors", label, test_errors);
            failed_tests++;
        end
        test_errors = 0;
    endtask

    task automatic wait_for_inst(output bit ok);
        int cycles;
        cycles = 0;
        while (inst_valid !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(posedge clock);
            #5;
            cycles++;
        end
        ok = (inst_valid === 1'b1);
    endtask

    // ------------------------------------------------------------------------
    // Receive, stall, act on and hand off one table row
    // ------------------------------------------------------------------------
    task automatic run_row(input int idx);
        row_t        r;
        logic [31:0] snap_pc;
        logic [31:0] snap_inst;
        bit          ok;
        r = rows[idx];
        pending_pc = r.pc;
        test_errors = 0;
        wait_for_inst(ok);
        if (!ok) begin
            $display("test %0d: timed out waiting for inst_valid at pc %h", idx, r.pc);
            errors++;
            tests++;
            failed_tests++;
            timed_out = 1'b1;
            return;
        end
        check_value("inst_pc", inst_pc, r.pc);
        check_value("inst", inst, mem_word(r.pc));
        snap_pc = inst_pc;
        snap_inst = inst;
        repeat (r.stall) begin
            @(posedge clock);
            #5;
            check_value("inst_valid", 32'(inst_valid), 32'd1);
            check_value("inst_pc", inst_pc, snap_pc);
            check_value("inst", inst, snap_inst);
        end
        // Last row is left waiting in the output register
        if (idx < rows.size() - 1) begin
            if (r.action == ACT_REDIRECT) begin
                redirect_valid = 1'b1;
                redirect_pc = r.target;
                @(posedge clock);
                #5;
                redirect_valid = 1'b0;
            end else if (r.action == ACT_HOLD) begin
                hold = 1'b1;
                @(posedge clock);
                #5;
                hold = 1'b0;
            end
            inst_ready = 1'b1;
            @(posedge clock);
            #5;
            inst_ready = 1'b0;
            check_value("inst_valid", 32'(inst_valid), 32'd0);
        end
        report_test($sformatf("%0d pc %h", idx, r.pc));
    endtask

    // ------------------------------------------------------------------------
    // Memory model serving one line burst at a time
    // ------------------------------------------------------------------------
    initial begin
        mem_ar_ready = 1'b0;
        mem_r_valid = 1'b0;
        mem_r = '0;
        burst_active = 1'b0;
        burst_addr = '0;
        beat_idx = 0;
        forever begin
            // Sample DUT outputs mid cycle
            @(negedge clock);
            ar_valid_s = mem_ar_valid;
            ar_s = mem_ar;
            r_ready_s = mem_r_ready;
            @(posedge clock);
            #5;
            if (reset) begin
                burst_active = 1'b0;
                mem_ar_ready = 1'b0;
                mem_r_valid = 1'b0;
            end else begin
                if (ar_valid_s === 1'b1 && mem_ar_ready) begin
                    burst_count++;
                    burst_active = 1'b1;
                    burst_addr = ar_s.addr;
                    beat_idx = 0;
                    check_value("mem_ar.len", 32'(ar_s.len), `ICACHE_LINE_WORDS - 1);
                    check_value("mem_ar.size", 32'(ar_s.size), 32'd2);
                    check_value("mem_ar.burst", 32'(ar_s.burst), 32'd1);
                    check_value("mem_ar.id", 32'(ar_s.id), `FETCH_AXI_ID);
                    check_value("mem_ar.addr", ar_s.addr,
                                pending_pc & ~32'(LINE_BYTES - 1));
                end
                if (mem_r_valid && r_ready_s === 1'b1) begin
                    mem_r_valid = 1'b0;
                    if (beat_idx == `ICACHE_LINE_WORDS - 1) begin
                        burst_active = 1'b0;
                    end else begin
                        beat_idx++;
                    end
                end
                // Random gaps between beats
                if (burst_active && !mem_r_valid && (($random(seed) & 3) != 0)) begin
                    mem_r_valid = 1'b1;
                    mem_r.data = mem_word(burst_addr + 32'(beat_idx * 4));
                    mem_r.id = 4'(`FETCH_AXI_ID);
                    mem_r.resp = 2'b00;
                    mem_r.last = (beat_idx == `ICACHE_LINE_WORDS - 1);
                end
                mem_ar_ready = (($random(seed) & 1) == 1);
            end
        end
    end

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        int cycles;
        redirect_valid = 1'b0;
        redirect_pc = '0;
        hold = 1'b0;
        inst_ready = 1'b0;
        pending_pc = `FETCH_RESET_PC;
        load_table();
        cycles = 0;
        while (reset !== 1'b0 && cycles < 20) begin
            @(negedge clock);
            cycles++;
        end
        if (reset !== 1'b0) begin
            $display("reset never released");
            errors++;
            timed_out = 1'b1;
        end else begin
            check_value("inst_valid", 32'(inst_valid), 32'd0);
            check_value("mem_ar_valid", 32'(mem_ar_valid), 32'd0);
            check_value("mem_r_ready", 32'(mem_r_ready), 32'd0);
            report_test("reset");
            @(posedge clock);
            #5;
        end
        for (int i = 0; i < rows.size() && !timed_out; i++) begin
            run_row(i);
        end
        if (!timed_out) begin
            check_value("burst_count", 32'(burst_count), 32'(count_lines()));
            report_test("burst count");
        end
        $display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
        if (errors == 0 && !timed_out) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* fetch_top.f */
+incdir+common
common/fetch_pkg.sv
hdl/fetch_unit.sv
icache/icache.sv
hdl/fetch_top.sv
tb/tb_clock.sv
tb/tb_fetch_top.sv

/* run.sh */
#!/bin/sh
# Build and run the fetch subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fetch_top \
    -f fetch_top.f \
    -Mdir obj_dir -o sim_fetch_top
status=$?
if [ $status -ne 0 ]; then
    echo "verilator compile failed with status $status"
    exit 1
fi

./obj_dir/sim_fetch_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TB PASSED$" "$LOG"; then
    exit 0
fi
exit 1
